/* build.f */
vec_fixed_pkg.sv
vec_op_pkg.sv
sync_fifo.sv
vec_decode.sv
vec_execute.sv
vec_result.sv
vec_unit.sv
vec_unit_sva.sv
vec_unit_tb.sv

/* Makefile */
# Verilator flow for the vector unit.

TOP := vec_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps -f build.f --top-module $(TOP)

sim:
	rm -f sim.log
	verilator --binary --timing --assert --timescale 1ns/10ps -f build.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* vec_unit_tb.sv */
`timescale 1ns/10ps

module vec_unit_tb;

    import vec_fixed_pkg::*;
    import vec_op_pkg::*;

    typedef struct packed {
        int      test;
        opcode_t op;
        vec3_t   x;
        vec3_t   y;
    } stim_t;

    typedef logic [$bits(vec_rsp_t)-1:0] word_t;

    localparam int wait_limit = 2000;  // Cycles per wait loop.
    localparam int burst_len  = 19;    // 8 + 8 in the FIFOs, 3 in the stages.
    localparam int long_len   = 60;

    logic     clock;
    logic     reset;
    vec_cmd_t cmd_in;
    logic     cmd_wr_en;
    logic     cmd_full;
    vec_rsp_t rsp_out;
    logic     rsp_empty;
    logic     rsp_rd_en;

    stim_t    stim_table [$];
    vec_rsp_t expect_q [$];
    tag_t     next_tag;
    bit       reader_paused;
    bit       timed_out;
    int       checks;
    int       errors;

    vec_unit dut (
        .clock     (clock),
        .reset     (reset),
        .cmd_in    (cmd_in),
        .cmd_wr_en (cmd_wr_en),
        .cmd_full  (cmd_full),
        .rsp_out   (rsp_out),
        .rsp_empty (rsp_empty),
        .rsp_rd_en (rsp_rd_en)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Bits 16..47 of the full product.
    function automatic fix_t mul_shift(fix_t a, fix_t b);
        wide_t p;
        p = wide_t'(a) * wide_t'(b);
        return p[q_frac +: 32];
    endfunction

    function automatic vec_rsp_t expected_rsp(vec_cmd_t c);
        vec_rsp_t r;
        r        = '0;
        r.tag    = c.tag;
        r.status = st_ok;
        case (c.opcode)
            op_dot: begin
                r.value.e0 = mul_shift(c.x.e0, c.y.e0) + mul_shift(c.x.e1, c.y.e1)
                           + mul_shift(c.x.e2, c.y.e2);
            end
            op_add: begin
                r.value.e0 = c.x.e0 + c.y.e0;
                r.value.e1 = c.x.e1 + c.y.e1;
                r.value.e2 = c.x.e2 + c.y.e2;
            end
            op_scale: begin
                r.value.e0 = mul_shift(c.x.e0, c.y.e0);
                r.value.e1 = mul_shift(c.x.e1, c.y.e0);
                r.value.e2 = mul_shift(c.x.e2, c.y.e0);
            end
            default: r.status = st_bad_op;
        endcase
        return r;
    endfunction

    //////////////////////////////
    // Stimulus table
    //////////////////////////////

    function automatic vec3_t make_vec(fix_t a, fix_t b, fix_t c);
        return '{a, b, c};
    endfunction

    function automatic vec3_t rand_vec();
        return '{fix_t'($urandom), fix_t'($urandom), fix_t'($urandom)};
    endfunction

    function automatic void add_entry(int test, opcode_t op, vec3_t x, vec3_t y);
        stim_table.push_back(stim_t'{test, op, x, y});
    endfunction

    function automatic void add_random(int test, int count);
        logic [1:0] code;
        for (int i = 0; i < count; i++) begin
            code = 2'($urandom % 4);
            add_entry(test, opcode_t'(code), rand_vec(), rand_vec());
        end
    endfunction

    function automatic void build_table();
        // Mixed signs, and tiny negatives that round down.
        add_entry(2, op_dot, make_vec(32'sh0001_8000, -32'sh0002_4000, 32'sh0000_c000),
                  make_vec(-32'sh0003_0000, 32'sh0000_8000, 32'sh0004_2000));
        add_entry(2, op_dot, make_vec(-32'sh0000_0005, 32'sh0123_4567, -32'sh0000_0001),
                  make_vec(32'sh0000_4ccd, -32'sh0000_0003, 32'sh0000_0001));
        add_entry(3, op_add, make_vec(32'sh7fff_ffff, 32'sh8000_0000, 32'sh0001_8000),
                  make_vec(32'sh0000_0001, -32'sh0000_0001, -32'sh0002_4000));
        add_entry(3, op_scale, make_vec(32'sh0001_8000, -32'sh0002_4000, 32'sh0064_0000),
                  make_vec(-32'sh0000_8000, 32'sh0007_0000, 32'sh0000_0000));
        add_entry(3, op_scale, make_vec(32'sh4000_0000, -32'sh0000_0003, 32'sh0000_0001),
                  make_vec(32'sh0004_0000, 32'sh0000_0000, 32'sh7fff_0000));
        // Reserved op between good ones.
        add_entry(4, op_rsvd, make_vec(32'sh0001_0000, 32'sh0002_0000, 32'sh0003_0000),
                  make_vec(32'sh0004_0000, 32'sh0005_0000, 32'sh0006_0000));
        add_entry(4, op_dot, make_vec(32'sh0001_0000, 32'sh0002_0000, 32'sh0003_0000),
                  make_vec(32'sh0004_0000, 32'sh0005_0000, 32'sh0006_0000));
        add_entry(4, op_add, make_vec(32'sh0001_0000, 32'sh0002_0000, 32'sh0003_0000),
                  make_vec(-32'sh0001_0000, 32'sh0000_8000, 32'sh0000_0000));
        add_random(5, burst_len);
        add_random(6, long_len);
    endfunction

    //////////////////////////////
    // Checks and waits
    //////////////////////////////

    task automatic compare_value(string name, word_t got, word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic write_cmd(stim_t s);
        int       n;
        vec_cmd_t c;
        n = 0;
        while (cmd_full && n < wait_limit) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (cmd_full) begin
            $display("test %0d: cmd_full stayed high, command not written", s.test);
            errors++;
            timed_out = 1'b1;
        end else begin
            c         = '{opcode: s.op, tag: next_tag, x: s.x, y: s.y};
            cmd_in    = c;
            cmd_wr_en = 1'b1;
            expect_q.push_back(expected_rsp(c));
            next_tag++;
            @(posedge clock);
            #1;
            cmd_wr_en = 1'b0;
        end
    endtask

    task automatic wait_full();
        int n;
        n = 0;
        while (!cmd_full && n < wait_limit) begin
            @(posedge clock);
            #1;
            n++;
        end
        compare_value("cmd_full", word_t'(cmd_full), word_t'(1'b1));
    endtask

    task automatic wait_drained(int t);
        int n;
        n = 0;
        while (expect_q.size() != 0 && n < wait_limit) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (expect_q.size() != 0) begin
            $display("test %0d: %0d results never came back", t, expect_q.size());
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_test(int t);
        int err0;
        int chk0;
        err0          = errors;
        chk0          = checks;
        reader_paused = (t == 5);  // Burst test holds the reader off.
        foreach (stim_table[i]) begin
            if (stim_table[i].test == t && !timed_out) begin
                write_cmd(stim_table[i]);
            end
        end
        if (t == 5) begin
            wait_full();
            reader_paused = 1'b0;
        end
        wait_drained(t);
        $display("test %0d done: %0d checks, %0d errors", t, checks - chk0, errors - err0);
    endtask

    //////////////////////////////
    // Reader
    //////////////////////////////

    initial begin
        rsp_rd_en = 1'b0;
        forever begin
            @(posedge clock);
            #1;
            rsp_rd_en = 1'b0;
            if (!reset && !reader_paused && !rsp_empty && ($urandom % 4) != 0) begin
                assert (expect_q.size() != 0) else begin
                    $display("extra result with tag %0d at %0t", rsp_out.tag, $time);
                    errors++;
                end
                if (expect_q.size() != 0) begin
                    compare_value("rsp_out", word_t'(rsp_out), word_t'(expect_q.pop_front()));
                end
                rsp_rd_en = 1'b1;
            end
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        void'($urandom(32'he31f_aaa3));
        reset         = 1'b1;
        cmd_in        = '0;
        cmd_wr_en     = 1'b0;
        reader_paused = 1'b0;
        timed_out     = 1'b0;
        checks        = 0;
        errors        = 0;
        next_tag      = '0;
        build_table();
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        compare_value("rsp_empty", word_t'(rsp_empty), word_t'(1'b1));
        compare_value("cmd_full", word_t'(cmd_full), word_t'(1'b0));
        $display("test 1 done: %0d checks, %0d errors", checks, errors);

        for (int t = 2; t <= 6; t++) begin
            if (!timed_out) begin
                run_test(t);
            end
        end

        // Nothing may trail the last expected result.
        repeat (20) @(posedge clock);
        #1;
        compare_value("rsp_empty", word_t'(rsp_empty), word_t'(1'b1));

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut.u_sva.assert_errors);
        if (errors == 0 && dut.u_sva.assert_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* vec_unit_sva.sv */
`timescale 1ns/10ps

module vec_unit_sva (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   cmd_wr_en,
    input  logic                   cmd_full,
    input  logic                   cmd_rd_en,
    input  logic                   cmd_empty,
    input  logic                   rsp_wr_en,
    input  logic                   rsp_full,
    input  logic                   rsp_rd_en,
    input  logic                   rsp_empty,
    input  logic                   execute_stall,
    input  vec_op_pkg::dec_op_t    dec_op,
    input  logic                   dec_valid,
    input  logic                   result_stall,
    input  vec_op_pkg::vec_rsp_t   exe_rsp,
    input  logic                   exe_valid
);

    import vec_op_pkg::*;

    int assert_errors = 0;  // Read by the testbench.
    int cmd_level;          // Shadow occupancy of the command FIFO.
    int rsp_level;          // Shadow occupancy of the result FIFO.

    //////////////////////////////
    // FIFO protocol
    //////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cmd_level <= 0;
            rsp_level <= 0;
        end else begin
            cmd_level <= cmd_level + int'(cmd_wr_en && !cmd_full) - int'(cmd_rd_en);
            rsp_level <= rsp_level + int'(rsp_wr_en) - int'(rsp_rd_en && !rsp_empty);
        end
    end

    rsp_write_room: assert property (@(posedge clock) disable iff (reset)
        rsp_wr_en |-> rsp_level < fifo_depth)
        else begin
            $error("result FIFO written while full");
            assert_errors++;
        end

    cmd_read_data: assert property (@(posedge clock) disable iff (reset)
        cmd_rd_en |-> cmd_level > 0)
        else begin
            $error("command FIFO read while empty");
            assert_errors++;
        end

    //////////////////////////////
    // Stalls
    //////////////////////////////

    decode_hold: assert property (@(posedge clock) disable iff (reset)
        dec_valid && execute_stall |=> dec_valid && $stable(dec_op))
        else begin
            $error("decode register moved while stalled");
            assert_errors++;
        end

    execute_hold: assert property (@(posedge clock) disable iff (reset)
        exe_valid && result_stall |=> exe_valid && $stable(exe_rsp))
        else begin
            $error("execute register moved while stalled");
            assert_errors++;
        end

    // Result FIFO starts out empty.
    empty_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> rsp_empty)
        else begin
            $error("rsp_empty low right after reset");
            assert_errors++;
        end

endmodule

bind vec_unit vec_unit_sva u_sva (.*);

/* vec_unit.sv */
`timescale 1ns/10ps

module vec_unit (
    input  logic                   clock,
    input  logic                   reset,

    input  vec_op_pkg::vec_cmd_t   cmd_in,
    input  logic                   cmd_wr_en,
    output logic                   cmd_full,

    output vec_op_pkg::vec_rsp_t   rsp_out,
    output logic                   rsp_empty,
    input  logic                   rsp_rd_en
);

    import vec_op_pkg::*;

    vec_cmd_t cmd_head;
    logic     cmd_empty;
    logic     cmd_rd_en;

    dec_op_t  dec_op;
    logic     dec_valid;
    logic     execute_stall;

    vec_rsp_t exe_rsp;
    logic     exe_valid;
    logic     result_stall;

    vec_rsp_t rsp_din;
    logic     rsp_wr_en;
    logic     rsp_full;

    //////////////////////////////
    // Command side
    //////////////////////////////

    sync_fifo #(
        .payload_t (vec_cmd_t),
        .depth     (fifo_depth)
    ) u_cmd_fifo (
        .clock     (clock),
        .reset     (reset),
        .wr_en     (cmd_wr_en),
        .din       (cmd_in),
        .full      (cmd_full),
        .rd_en     (cmd_rd_en),
        .dout      (cmd_head),
        .empty     (cmd_empty)
    );

    vec_decode u_decode (
        .clock         (clock),
        .reset         (reset),
        .cmd           (cmd_head),
        .cmd_empty     (cmd_empty),
        .cmd_rd_en     (cmd_rd_en),
        .execute_stall (execute_stall),
        .dec_op        (dec_op),
        .dec_valid     (dec_valid)
    );

    vec_execute u_execute (
        .clock         (clock),
        .reset         (reset),
        .dec_op        (dec_op),
        .dec_valid     (dec_valid),
        .execute_stall (execute_stall),
        .result_stall  (result_stall),
        .exe_rsp       (exe_rsp),
        .exe_valid     (exe_valid)
    );

    //////////////////////////////
    // Result side
    //////////////////////////////

    vec_result u_result (
        .clock        (clock),
        .reset        (reset),
        .exe_rsp      (exe_rsp),
        .exe_valid    (exe_valid),
        .result_stall (result_stall),
        .rsp_full     (rsp_full),
        .rsp_wr_en    (rsp_wr_en),
        .rsp_din      (rsp_din)
    );

    sync_fifo #(
        .payload_t (vec_rsp_t),
        .depth     (fifo_depth)
    ) u_rsp_fifo (
        .clock     (clock),
        .reset     (reset),
        .wr_en     (rsp_wr_en),
        .din       (rsp_din),
        .full      (rsp_full),
        .rd_en     (rsp_rd_en),
        .dout      (rsp_out),
        .empty     (rsp_empty)
    );

endmodule

/* vec_result.sv */
`timescale 1ns/10ps

module vec_result (
    input  logic                   clock,
    input  logic                   reset,

    input  vec_op_pkg::vec_rsp_t   exe_rsp,
    input  logic                   exe_valid,
    output logic                   result_stall,

    input  logic                   rsp_full,
    output logic                   rsp_wr_en,
    output vec_op_pkg::vec_rsp_t   rsp_din
);

    logic     rsp_held;    // Record waiting for the FIFO.

    //////////////////////////////
    // Write and stall
    //////////////////////////////

    // Write as soon as a record is held and there is room.
    assign rsp_wr_en    = rsp_held && !rsp_full;
    assign result_stall = rsp_held && rsp_full;

    //////////////////////////////
    // Holding register
    //////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rsp_held <= 1'b0;
        end else if (!result_stall) begin
            rsp_held <= exe_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!result_stall && exe_valid) begin
            rsp_din <= exe_rsp;
        end
    end

endmodule

/* vec_execute.sv */
`timescale 1ns/10ps

module vec_execute (
    input  logic                   clock,
    input  logic                   reset,

    input  vec_op_pkg::dec_op_t    dec_op,
    input  logic                   dec_valid,
    output logic                   execute_stall,

    input  logic                   result_stall,
    output vec_op_pkg::vec_rsp_t   exe_rsp,
    output logic                   exe_valid
);

    import vec_fixed_pkg::*;
    import vec_op_pkg::*;

    fix_t     x_el   [3];
    fix_t     y_el   [3];
    fix_t     m_el   [3];   // Second factor per lane.
    wide_t    prod_w [3];
    fix_t     prod   [3];
    fix_t     dot_sum;
    vec_rsp_t rsp_c;

    //////////////////////////////
    // Multiply and shift
    //////////////////////////////

    always_comb begin
        x_el[0] = dec_op.x.e0;
        x_el[1] = dec_op.x.e1;
        x_el[2] = dec_op.x.e2;
        y_el[0] = dec_op.y.e0;
        y_el[1] = dec_op.y.e1;
        y_el[2] = dec_op.y.e2;
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            // SCALE uses y.e0 in every lane.
            m_el[i]   = (dec_op.op == op_scale) ? y_el[0] : y_el[i];
            prod_w[i] = wide_t'(x_el[i]) * wide_t'(m_el[i]);
            prod[i]   = fix_t'(prod_w[i] >>> q_frac);  // Back to Q16.16, low bits kept.
        end
        dot_sum = prod[0] + prod[1] + prod[2];
    end

    //////////////////////////////
    // Result select
    //////////////////////////////

    always_comb begin
        rsp_c        = '0;
        rsp_c.tag    = dec_op.tag;
        rsp_c.status = st_ok;
        if (dec_op.bad) begin
            rsp_c.status = st_bad_op;    // Value stays zero.
        end else begin
            case (dec_op.op)
                op_dot: begin
                    rsp_c.value.e0 = dot_sum;
                end
                op_add: begin
                    rsp_c.value.e0 = x_el[0] + y_el[0];  // Wraps.
                    rsp_c.value.e1 = x_el[1] + y_el[1];
                    rsp_c.value.e2 = x_el[2] + y_el[2];
                end
                op_scale: begin
                    rsp_c.value.e0 = prod[0];
                    rsp_c.value.e1 = prod[1];
                    rsp_c.value.e2 = prod[2];
                end
                default: begin
                    rsp_c.status = st_bad_op;
                end
            endcase
        end
    end

    //////////////////////////////
    // Stage register
    //////////////////////////////

    assign execute_stall = exe_valid && result_stall;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else if (!execute_stall) begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!execute_stall && dec_valid) begin
            exe_rsp <= rsp_c;
        end
    end

endmodule

/* vec_decode.sv */
`timescale 1ns/10ps

module vec_decode (
    input  logic                   clock,
    input  logic                   reset,

    input  vec_op_pkg::vec_cmd_t   cmd,
    input  logic                   cmd_empty,
    output logic                   cmd_rd_en,

    input  logic                   execute_stall,
    output vec_op_pkg::dec_op_t    dec_op,
    output logic                   dec_valid
);

    import vec_op_pkg::*;

    logic take;

    //////////////////////////////
    // Pop control
    //////////////////////////////

    // Free, or the held item moves on this edge.
    assign take = !dec_valid || !execute_stall;

    assign cmd_rd_en = !cmd_empty && take;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (take) begin
            dec_valid <= cmd_rd_en;  // Empty when nothing was popped.
        end
    end

    //////////////////////////////
    // Decoded operation
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (cmd_rd_en) begin
            dec_op.tag <= cmd.tag;
            dec_op.op  <= cmd.opcode;
            dec_op.x   <= cmd.x;
            dec_op.y   <= cmd.y;
            // Only the reserved code is unsupported.
            case (cmd.opcode)
                op_dot,
                op_add,
                op_scale: dec_op.bad <= 1'b0;
                default:  dec_op.bad <= 1'b1;
            endcase
        end
    end

endmodule

/* sync_fifo.sv */
`timescale 1ns/10ps

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 8
) (
    input  logic     clock,
    input  logic     reset,

    input  logic     wr_en,
    input  payload_t din,
    output logic     full,

    input  logic     rd_en,
    output payload_t dout,
    output logic     empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t           mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic [cnt_w-1:0]   count_next;
    logic               wr_ok;
    logic               rd_ok;

    assign wr_ok = wr_en && !full;   // Writes into a full FIFO are dropped.
    assign rd_ok = rd_en && !empty;

    // Show-ahead read port.
    assign dout = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (wr_ok && !rd_ok) begin
            count_next = count + 1'b1;
        end else if (rd_ok && !wr_ok) begin
            count_next = count - 1'b1;
        end
    end

    //////////////////////////////
    // Pointers and flags
    //////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            full  <= (count_next == cnt_w'(depth));
            empty <= (count_next == '0);
        end
    end

    // Storage.
    always_ff @(posedge clock) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

/* vec_op_pkg.sv */
package vec_op_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int tag_width  = 8;
    localparam int fifo_depth = 8;  // Command and result FIFOs.

    //////////////////////////////
    // Codes
    //////////////////////////////

    typedef enum logic [1:0] {
        op_dot   = 2'd0,
        op_add   = 2'd1,
        op_scale = 2'd2,
        op_rsvd  = 2'd3   // Rejected by decode.
    } opcode_t;

    typedef enum logic {
        st_ok     = 1'b0,
        st_bad_op = 1'b1
    } status_t;

    typedef logic [tag_width-1:0] tag_t;

    //////////////////////////////
    // Records
    //////////////////////////////

    // Host command, as written into the command FIFO.
    typedef struct packed {
        opcode_t               opcode;
        tag_t                  tag;
        vec_fixed_pkg::vec3_t  x;
        vec_fixed_pkg::vec3_t  y;
    } vec_cmd_t;

    // Result record, as read back by the host.
    typedef struct packed {
        tag_t                  tag;
        status_t               status;
        vec_fixed_pkg::vec3_t  value;
    } vec_rsp_t;

    // Decode to execute.
    typedef struct packed {
        tag_t                  tag;
        logic                  bad;    // Opcode not supported.
        opcode_t               op;
        vec_fixed_pkg::vec3_t  x;
        vec_fixed_pkg::vec3_t  y;
    } dec_op_t;

endpackage

/* vec_fixed_pkg.sv */
package vec_fixed_pkg;

    //////////////////////////////
    // Q16.16 format
    //////////////////////////////

    localparam int fix_width  = 32;
    localparam int q_frac     = 16;             // Fraction bits.
    localparam int wide_width = 2 * fix_width;  // Full product width.

    //////////////////////////////
    // Scalar types
    //////////////////////////////

    // One signed fixed-point element.
    typedef logic signed [fix_width-1:0] fix_t;

    // Raw product of two elements, before the shift back to Q16.16.
    typedef logic signed [wide_width-1:0] wide_t;

    //////////////////////////////
    // Vector type
    //////////////////////////////

    // Three-element vector.
    // e0 sits in the top bits of the packed value.
    typedef struct packed {
        fix_t e0;
        fix_t e1;
        fix_t e2;
    } vec3_t;

endpackage
